// File: fe_pkg.sv
/*
  Shared definitions for the fetch front end: address and instruction
  widths, command and queue enums, and the packed command, queue entry
  and redirect structs
*/
package fe_pkg;

  localparam int vaddr_width_c = 32;
  localparam int instr_width_c = 32;

  // User mode may not fetch below this address
  localparam logic [vaddr_width_c-1:0] user_base_c = 32'h0000_1000;

  typedef enum logic [1:0] {
    e_op_pc_redirect = 2'd0,
    e_op_state_reset = 2'd1,
    e_op_wait        = 2'd2
  } fe_cmd_op_e;

  typedef enum logic [1:0] {
    e_subop_redirect = 2'd0,
    e_subop_trap     = 2'd1,
    e_subop_eret     = 2'd2
  } fe_subop_e;

  typedef enum logic {
    e_priv_user    = 1'b0,
    e_priv_machine = 1'b1
  } priv_e;

  typedef enum logic [1:0] {
    e_instr_fetch        = 2'd0,
    e_instr_access_fault = 2'd1,
    e_instr_misaligned   = 2'd2
  } fe_msg_e;

  typedef enum logic [1:0] {
    e_wait  = 2'd0,
    e_run   = 2'd1,
    e_stall = 2'd2
  } fe_state_e;

  typedef struct packed {
    fe_cmd_op_e               opcode;
    fe_subop_e                subopcode;
    logic [vaddr_width_c-1:0] npc;
    priv_e                    priv;
  } fe_cmd_s;

  // Instr field is zero for exception entries
  typedef struct packed {
    fe_msg_e                  msg_type;
    logic [vaddr_width_c-1:0] pc;
    logic [instr_width_c-1:0] instr;
  } fe_queue_s;

  // Resume selects the PC held in the PC generator instead of pc
  typedef struct packed {
    logic                     v;
    logic                     resume;
    logic [vaddr_width_c-1:0] pc;
  } fe_redirect_s;

endpackage

// File: fe_controller.sv
/*
  Front end controller: command decode and acceptance, shadow privilege
  and the wait/run/stall fetch state machine
*/
`timescale 1ns/100ps

module fe_controller
  (input  logic                 clk_i,
   input  logic                 reset_i,

   input  fe_pkg::fe_cmd_s      fe_cmd_i,
   input  logic                 fe_cmd_v_i,
   output logic                 fe_cmd_yumi_o,

   input  logic                 fetch_fail_i,
   input  logic                 fetch_exception_i,
   input  logic                 fe_queue_ready_i,

   output fe_pkg::fe_redirect_s redirect_o,
   output logic                 fetch_en_o,
   output logic                 poison_o,
   output fe_pkg::priv_e        priv_o);

  import fe_pkg::*;

  fe_state_e state_r;
  fe_state_e state_n;
  priv_e     priv_r;

  logic cmd_v;
  logic redirect_v;
  logic state_reset_v;
  logic wait_v;
  logic trap_v;
  logic eret_v;
  logic priv_w;
  logic resume_v;

  // Commands are consumed the cycle they show up
  assign cmd_v         = fe_cmd_v_i & ~reset_i;
  assign fe_cmd_yumi_o = cmd_v;

  assign redirect_v    = cmd_v & (fe_cmd_i.opcode == e_op_pc_redirect);
  assign state_reset_v = cmd_v & (fe_cmd_i.opcode == e_op_state_reset);
  assign wait_v        = cmd_v & (fe_cmd_i.opcode == e_op_wait);
  assign trap_v        = redirect_v & (fe_cmd_i.subopcode == e_subop_trap);
  assign eret_v        = redirect_v & (fe_cmd_i.subopcode == e_subop_eret);
  assign priv_w        = state_reset_v | trap_v | eret_v;

  // Bypass so a trap fetches its first PC at the new privilege
  assign priv_o = priv_w ? fe_cmd_i.priv : priv_r;

  always_comb
  begin
    state_n = state_r;
    if (redirect_v)
      state_n = e_run;
    else if (wait_v)
      state_n = e_wait;
    else if (cmd_v)
      state_n = e_stall;
    else
    begin
      case (state_r)
        e_run:
        begin
          if (fetch_fail_i)
            state_n = e_stall;
          else if (fetch_exception_i)
            state_n = e_wait;
        end
        e_stall:
        begin
          if (fe_queue_ready_i)
            state_n = e_run;
        end
        e_wait:
          state_n = e_wait;
        default:
          state_n = e_wait;
      endcase
    end
  end

  // Leaving stall refetches from the resume PC
  assign resume_v = (state_r == e_stall) & ~cmd_v & fe_queue_ready_i;

  assign redirect_o.v      = redirect_v | state_reset_v | resume_v;
  assign redirect_o.resume = resume_v;
  assign redirect_o.pc     = fe_cmd_i.npc;

  assign fetch_en_o = (state_n == e_run);
  assign poison_o   = cmd_v | fetch_fail_i;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r <= e_wait;
      priv_r  <= e_priv_machine;
    end
    else
    begin
      state_r <= state_n;
      if (priv_w)
        priv_r <= fe_cmd_i.priv;
    end
  end

  a_state_legal: assert property (@(posedge clk_i) disable iff (reset_i)
    state_r inside {e_wait, e_run, e_stall})
    else $error("fe_controller: illegal state %0d", state_r);

  a_yumi_needs_valid: assert property (@(posedge clk_i)
    fe_cmd_yumi_o |-> fe_cmd_v_i)
    else $error("fe_controller: yumi without valid");

endmodule

// File: fe_pc_gen.sv
/*
  Fetch PC generator for IF0: next-PC select, fetch PC register and
  resume PC register used to refetch after a stall
*/
`timescale 1ns/100ps

module fe_pc_gen
  #(parameter int vaddr_width_p = fe_pkg::vaddr_width_c)
  (input  logic                     clk_i,
   input  logic                     reset_i,

   input  fe_pkg::fe_redirect_s     redirect_i,
   input  logic                     fetch_en_i,
   input  logic [vaddr_width_p-1:0] fail_pc_i,
   input  logic                     fetch_fail_i,

   output logic [vaddr_width_p-1:0] imem_addr_o,
   output logic                     imem_v_o,
   output logic [vaddr_width_p-1:0] if0_pc_o);

  logic [vaddr_width_p-1:0] pc_r;
  logic [vaddr_width_p-1:0] resume_r;
  logic [vaddr_width_p-1:0] pc_n;
  logic [vaddr_width_p-1:0] redirect_pc;

  assign redirect_pc = vaddr_width_p'(redirect_i.pc);

  always_comb
  begin
    if (redirect_i.v & redirect_i.resume)
      pc_n = resume_r;
    else if (redirect_i.v)
      pc_n = redirect_pc;
    else
      pc_n = pc_r + vaddr_width_p'(4);
  end

  assign imem_addr_o = pc_n;
  assign imem_v_o    = fetch_en_i;
  assign if0_pc_o    = pc_n;

  // Last issued PC, the base for sequential fetch
  always_ff @(posedge clk_i)
  begin
    if (fetch_en_i)
      pc_r <= pc_n;
  end

  // A command beats a refused fetch in the same cycle
  always_ff @(posedge clk_i)
  begin
    if (redirect_i.v & ~redirect_i.resume)
      resume_r <= redirect_pc;
    else if (fetch_fail_i)
      resume_r <= fail_pc_i;
  end

  a_no_fetch_in_reset: assert property (@(posedge clk_i)
    reset_i |-> !imem_v_o)
    else $error("fe_pc_gen: fetch issued during reset");

endmodule

// File: fe_fetch_pipe.sv
/*
  IF1/IF2 fetch pipeline: fault check on the issued PC, queue entry
  formation with the memory data, and refused-fetch detection
*/
`timescale 1ns/100ps

module fe_fetch_pipe
  #(parameter int vaddr_width_p = fe_pkg::vaddr_width_c,
    parameter int instr_width_p = fe_pkg::instr_width_c,
    parameter logic [vaddr_width_p-1:0] user_base_p = fe_pkg::user_base_c)
  (input  logic                     clk_i,
   input  logic                     reset_i,

   input  logic                     imem_v_i,
   input  logic [vaddr_width_p-1:0] if0_pc_i,
   input  logic [instr_width_p-1:0] imem_data_i,
   input  fe_pkg::priv_e            priv_i,
   input  logic                     poison_i,
   input  logic                     fe_queue_ready_i,

   output fe_pkg::fe_queue_s        fe_queue_o,
   output logic                     fe_queue_v_o,
   output logic                     fetch_fail_o,
   output logic                     fetch_exception_o,
   output logic [vaddr_width_p-1:0] fail_pc_o);

  import fe_pkg::*;

  logic                     if1_v_r;
  logic                     if2_v_r;
  logic                     if2_v_n;
  logic [vaddr_width_p-1:0] if1_pc_r;
  fe_msg_e                  if0_msg;
  fe_msg_e                  if1_msg_r;
  fe_queue_s                if2_entry_n;
  fe_queue_s                if2_entry_r;

  // Misaligned wins over access fault
  always_comb
  begin
    if (if0_pc_i[1:0] != 2'b00)
      if0_msg = e_instr_misaligned;
    else if ((priv_i == e_priv_user) && (if0_pc_i < user_base_p))
      if0_msg = e_instr_access_fault;
    else
      if0_msg = e_instr_fetch;
  end

  always_comb
  begin
    if2_entry_n          = '0;
    if2_entry_n.msg_type = if1_msg_r;
    if2_entry_n.pc       = if1_pc_r;
    if (if1_msg_r == e_instr_fetch)
      if2_entry_n.instr = imem_data_i;
  end

  // Younger fetches die behind a command, a refusal or a sent exception
  assign if2_v_n = if1_v_r & ~poison_i & ~fetch_exception_o;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      if1_v_r <= 1'b0;
      if2_v_r <= 1'b0;
    end
    else
    begin
      if1_v_r <= imem_v_i;
      if2_v_r <= if2_v_n;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (imem_v_i)
    begin
      if1_pc_r  <= if0_pc_i;
      if1_msg_r <= if0_msg;
    end
    if (if1_v_r)
      if2_entry_r <= if2_entry_n;
  end

  assign fe_queue_o        = if2_entry_r;
  assign fe_queue_v_o      = if2_v_r & fe_queue_ready_i & ~poison_i;
  assign fetch_fail_o      = if2_v_r & ~fe_queue_ready_i;
  assign fetch_exception_o = fe_queue_v_o & (if2_entry_r.msg_type != e_instr_fetch);
  assign fail_pc_o         = vaddr_width_p'(if2_entry_r.pc);

  a_queue_v_needs_ready: assert property (@(posedge clk_i) disable iff (reset_i)
    fe_queue_v_o |-> fe_queue_ready_i)
    else $error("fe_fetch_pipe: queue valid while not ready");

  // A refused entry must be refetched, not left in IF2
  a_fail_flushes_if2: assert property (@(posedge clk_i) disable iff (reset_i)
    fetch_fail_o |=> !if2_v_r)
    else $error("fe_fetch_pipe: IF2 valid after refused fetch");

endmodule

// File: fe_top.sv
/*
  Fetch front end top level: controller, PC generator and
  two-stage fetch pipeline
*/
`timescale 1ns/100ps

module fe_top
  #(parameter int vaddr_width_p = fe_pkg::vaddr_width_c,
    parameter int instr_width_p = fe_pkg::instr_width_c,
    parameter logic [vaddr_width_p-1:0] user_base_p = fe_pkg::user_base_c)
  (input  logic                     clk_i,
   input  logic                     reset_i,

   input  fe_pkg::fe_cmd_s          fe_cmd_i,
   input  logic                     fe_cmd_v_i,
   output logic                     fe_cmd_yumi_o,

   output fe_pkg::fe_queue_s        fe_queue_o,
   output logic                     fe_queue_v_o,
   input  logic                     fe_queue_ready_i,

   output logic [vaddr_width_p-1:0] imem_addr_o,
   output logic                     imem_v_o,
   input  logic [instr_width_p-1:0] imem_data_i);

  import fe_pkg::*;

  fe_redirect_s             redirect;
  priv_e                    priv;
  logic                     fetch_en;
  logic                     poison;
  logic                     fetch_fail;
  logic                     fetch_exception;
  logic [vaddr_width_p-1:0] fail_pc;
  logic [vaddr_width_p-1:0] if0_pc;

  fe_controller u_controller
    (.clk_i             (clk_i),
     .reset_i           (reset_i),
     .fe_cmd_i          (fe_cmd_i),
     .fe_cmd_v_i        (fe_cmd_v_i),
     .fe_cmd_yumi_o     (fe_cmd_yumi_o),
     .fetch_fail_i      (fetch_fail),
     .fetch_exception_i (fetch_exception),
     .fe_queue_ready_i  (fe_queue_ready_i),
     .redirect_o        (redirect),
     .fetch_en_o        (fetch_en),
     .poison_o          (poison),
     .priv_o            (priv));

  fe_pc_gen #(.vaddr_width_p(vaddr_width_p)) u_pc_gen
    (.clk_i        (clk_i),
     .reset_i      (reset_i),
     .redirect_i   (redirect),
     .fetch_en_i   (fetch_en),
     .fail_pc_i    (fail_pc),
     .fetch_fail_i (fetch_fail),
     .imem_addr_o  (imem_addr_o),
     .imem_v_o     (imem_v_o),
     .if0_pc_o     (if0_pc));

  fe_fetch_pipe
    #(.vaddr_width_p(vaddr_width_p),
      .instr_width_p(instr_width_p),
      .user_base_p  (user_base_p))
  u_fetch_pipe
    (.clk_i             (clk_i),
     .reset_i           (reset_i),
     .imem_v_i          (imem_v_o),
     .if0_pc_i          (if0_pc),
     .imem_data_i       (imem_data_i),
     .priv_i            (priv),
     .poison_i          (poison),
     .fe_queue_ready_i  (fe_queue_ready_i),
     .fe_queue_o        (fe_queue_o),
     .fe_queue_v_o      (fe_queue_v_o),
     .fetch_fail_o      (fetch_fail),
     .fetch_exception_o (fetch_exception),
     .fail_pc_o         (fail_pc));

endmodule

// File: fe_top_tb.sv
/*
  Testbench for the fetch front end: clock, reset, memory model,
  command driver from the stimulus file, queue sink with LFSR ready,
  ordered entry checks and watchdog
*/
`timescale 1ns/100ps

module fe_top_tb;

  import fe_pkg::*;

  logic        clk_i;
  logic        reset_i;
  fe_cmd_s     fe_cmd_i;
  logic        fe_cmd_v_i;
  logic        fe_cmd_yumi_o;
  fe_queue_s   fe_queue_o;
  logic        fe_queue_v_o;
  logic        fe_queue_ready_i;
  logic [31:0] imem_addr_o;
  logic        imem_v_o;
  logic [31:0] imem_data_i;

  logic [31:0] mem [logic [31:0]];
  logic [31:0] lfsr;
  int          value_errors;
  int          stream_errors;
  int          cycle;
  int          cmd_cycle;
  int          block_left;
  int          block_taken;
  int          block_lat;
  int          limit_cycles;
  logic        rdy_mode;
  fe_queue_s   exp_q [$];

  fe_top #(.vaddr_width_p(32), .instr_width_p(32), .user_base_p(user_base_c)) dut_i
    (.clk_i(clk_i), .reset_i(reset_i),
     .fe_cmd_i(fe_cmd_i), .fe_cmd_v_i(fe_cmd_v_i), .fe_cmd_yumi_o(fe_cmd_yumi_o),
     .fe_queue_o(fe_queue_o), .fe_queue_v_o(fe_queue_v_o),
     .fe_queue_ready_i(fe_queue_ready_i),
     .imem_addr_o(imem_addr_o), .imem_v_o(imem_v_o), .imem_data_i(imem_data_i));

  always #50 clk_i = ~clk_i;

  // Synchronous memory, one cycle of read latency
  always @(posedge clk_i)
  begin
    if (imem_v_o)
      imem_data_i <= mem.exists(imem_addr_o) ? mem[imem_addr_o] : ~imem_addr_o;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hb4bc_d35c) : (s >> 1);
  endfunction

  // Ready drops on about one cycle in four
  task automatic draw_ready(output logic rdy);
    logic b0;
    logic b1;
    b0 = lfsr[0];
    lfsr = lfsr_next(lfsr);
    b1 = lfsr[0];
    lfsr = lfsr_next(lfsr);
    rdy = ~(b0 & b1);
  endtask

  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    if (got !== exp)
    begin
      value_errors++;
      $display("[FAIL] %0t %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic take_entry();
    fe_queue_s e;
    compare_value("fe_queue_ready_i", 64'(fe_queue_ready_i), 64'd1);
    if (block_left == 0)
    begin
      stream_errors++;
      $display("Unexpected queue entry at pc %0h at time %0t", fe_queue_o.pc, $time);
    end
    else
    begin
      e = exp_q.pop_front();
      if (block_taken == 0 && block_lat != 0)
        compare_value("first entry latency", 64'(cycle - cmd_cycle), 64'(block_lat));
      compare_value("fe_queue_o.msg_type", 64'(fe_queue_o.msg_type), 64'(e.msg_type));
      compare_value("fe_queue_o.pc", 64'(fe_queue_o.pc), 64'(e.pc));
      compare_value("fe_queue_o.instr", 64'(fe_queue_o.instr), 64'(e.instr));
      block_left--;
      block_taken++;
    end
  endtask

  // Sample at the rising edge, drive at the falling edge
  task automatic step();
    logic rdy;
    @(posedge clk_i);
    cycle++;
    if (fe_cmd_v_i)
    begin
      compare_value("fe_cmd_yumi_o", 64'(fe_cmd_yumi_o), 64'd1);
      cmd_cycle = cycle;
    end
    if (fe_queue_v_o)
      take_entry();
    @(negedge clk_i);
    fe_cmd_v_i = 1'b0;
    rdy = 1'b1;
    if (rdy_mode)
      draw_ready(rdy);
    fe_queue_ready_i = rdy;
  endtask

  initial
  begin
    limit_cycles = 0;
    wait (limit_cycles != 0);
    #(limit_cycles * 100);
    $display("Watchdog expired after %0d cycles, the DUT stopped responding", limit_cycles);
    $display("Test failed");
    $finish;
  end

  initial
  begin
    int fd;
    int r;
    int idle;
    int op;
    int sub;
    int pv;
    int rm;
    int lat;
    int n;
    int b;
    logic [31:0] a;
    logic [31:0] d;
    byte kind;
    string line;
    string body;
    fe_queue_s e;
    fe_cmd_s c;
    int idle_q [$];
    int rdy_q [$];
    int lat_q [$];
    int cnt_q [$];
    fe_cmd_s cmd_q [$];

    clk_i = 1'b0;
    reset_i = 1'b1;
    fe_cmd_i = '0;
    // A redirect is offered during reset and must not be taken
    fe_cmd_v_i = 1'b1;
    fe_queue_ready_i = 1'b1;
    imem_data_i = '0;
    lfsr = 32'h5b74;
    value_errors = 0;
    stream_errors = 0;
    cycle = 0;
    cmd_cycle = 0;
    block_left = 0;
    block_taken = 0;
    block_lat = 0;
    rdy_mode = 1'b0;

    fd = $fopen("fe_top_stim.txt", "r");
    if (fd == 0)
      $display("Could not open the stimulus file fe_top_stim.txt");
    while (fd != 0 && !$feof(fd))
    begin
      r = $fgets(line, fd);
      if (r == 0 || line.len() < 3 || line.getc(0) == "#")
        continue;
      kind = line.getc(0);
      body = line.substr(2, line.len() - 1);
      if (kind == "M")
      begin
        r = $sscanf(body, "%h %h", a, d);
        mem[a] = d;
      end
      else if (kind == "C")
      begin
        r = $sscanf(body, "%d %d %d %h %d %d %d", idle, op, sub, a, pv, rm, lat);
        c.opcode = fe_cmd_op_e'(op[1:0]);
        c.subopcode = fe_subop_e'(sub[1:0]);
        c.npc = a;
        c.priv = priv_e'(pv[0]);
        cmd_q.push_back(c);
        idle_q.push_back(idle);
        rdy_q.push_back(rm);
        lat_q.push_back(lat);
        cnt_q.push_back(0);
      end
      else if (kind == "E")
      begin
        r = $sscanf(body, "%d %h %h", op, a, d);
        e.msg_type = fe_msg_e'(op[1:0]);
        e.pc = a;
        e.instr = d;
        exp_q.push_back(e);
        cnt_q[cnt_q.size() - 1]++;
      end
    end
    if (fd != 0)
      $fclose(fd);
    if (cmd_q.size() == 0)
    begin
      stream_errors++;
      $display("The stimulus file holds no commands");
    end

    n = 16 + 50;
    foreach (idle_q[i])
      n += idle_q[i] + 10 + 12 * cnt_q[i];
    limit_cycles = n;

    // Outputs must stay quiet while reset is held
    repeat (16)
    begin
      @(posedge clk_i);
      compare_value("fe_queue_v_o", 64'(fe_queue_v_o), 64'd0);
      compare_value("imem_v_o", 64'(imem_v_o), 64'd0);
      compare_value("fe_cmd_yumi_o", 64'(fe_cmd_yumi_o), 64'd0);
      @(negedge clk_i);
    end
    reset_i = 1'b0;
    fe_cmd_v_i = 1'b0;

    for (b = 0; b < cmd_q.size(); b++)
    begin
      repeat (idle_q[b])
        step();
      fe_cmd_i = cmd_q[b];
      fe_cmd_v_i = 1'b1;
      rdy_mode = (rdy_q[b] != 0);
      block_left = cnt_q[b];
      block_taken = 0;
      block_lat = lat_q[b];
      step();
      n = 0;
      while (block_left > 0 && n < 200)
      begin
        step();
        n++;
      end
      if (block_left > 0)
      begin
        stream_errors++;
        $display("Command block %0d is missing %0d queue entries", b, block_left);
        repeat (block_left)
          e = exp_q.pop_front();
        block_left = 0;
      end
    end
    rdy_mode = 1'b0;
    repeat (8)
      step();

    $display("Done: %0d value errors, %0d stream errors", value_errors, stream_errors);
    if (value_errors == 0 && stream_errors == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

// File: fe_top_stim.txt
# M <addr hex> <word hex> | C <idle> <opcode> <subop> <npc hex> <priv> <lfsr ready> <latency>
# E <msg type> <pc hex> <instr hex>; unloaded words read as the inverted address
M 00000100 00000013
M 00000104 00a00093
M 00000108 00108113
M 0000010c 40208233
C 2 0 0 00000100 1 0 2
E 0 00000100 00000013
E 0 00000104 00a00093
E 0 00000108 00108113
E 0 0000010c 40208233
C 0 0 0 00000200 1 1 0
E 0 00000200 fffffdff
E 0 00000204 fffffdfb
E 0 00000208 fffffdf7
E 0 0000020c fffffdf3
E 0 00000210 fffffdef
E 0 00000214 fffffdeb
E 0 00000218 fffffde7
E 0 0000021c fffffde3
C 0 2 0 00000000 1 0 0
C 6 0 1 00000800 0 0 2
E 1 00000800 00000000
C 5 1 0 00000800 1 0 3
E 0 00000800 fffff7ff
E 0 00000804 fffff7fb
C 0 0 2 00000102 1 0 2
E 2 00000102 00000000
C 5 0 0 00000108 1 0 2
E 0 00000108 00108113
E 0 0000010c 40208233
C 0 2 0 00000000 1 0 0

// File: fe_top.f
fe_pkg.sv
fe_controller.sv
fe_pc_gen.sv
fe_fetch_pipe.sv
fe_top.sv
fe_top_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the fetch front end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f fe_top.f --top-module fe_top_tb -o fe_top_sim
./obj_dir/fe_top_sim | tee sim.log

if grep -q "Test failed" sim.log; then
  echo "Simulation reported failure"
  exit 1
fi
echo "Simulation finished without failure"
